// ==== vlog.f ====
source/ex_pkg.sv
source/ex_decode.sv
source/ex_bitcount.sv
source/ex_execute.sv
source/ex_result.sv
source/ex_stage_top.sv
verif/tb_clock_gen.sv
verif/ex_stage_tb.sv

// ==== verif/ex_stage_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_stage_tb;

    localparam int RESET_CYCLES     = 3;
    localparam int MAX_COUNT_CYCLES = 33;
    localparam int STALL_MARGIN     = 32;
    localparam logic [31:0] ALU_PC  = 32'h0040_0000;
    localparam logic [31:0] BR_PC   = 32'h0040_0100;
    localparam logic [31:0] J_PC    = 32'h1040_0100;
    localparam logic [4:0]  CODE_RI = 5'h0a;
    localparam logic [4:0]  CODE_OV = 5'h0c;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] result;
        logic [4:0]  waddr;
        logic        chk_res;
        logic        branch;
        logic [31:0] target;
        logic        exc;
        logic [4:0]  code;
        logic [5:0]  min_wait;
    } entry_t;

    logic        clk;
    logic        resetn;
    logic        valid;
    logic        ready;
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic        done;
    logic        valid_out;
    logic        branch;
    logic        exc;
    logic [31:0] target_pc;
    logic [31:0] result;
    logic [4:0]  waddr;
    logic [4:0]  exc_code;

    entry_t      tests[$];
    int          error_count;
    int          cur_idx;
    int          limit_cycles = 0;
    int unsigned rand_word;

    // model of the output register
    logic        exp_valid;
    logic        exp_chk;
    logic [31:0] exp_result;
    logic [4:0]  exp_waddr;
    logic [31:0] prev_result;
    logic [4:0]  prev_waddr;
    logic        last_ready;

    tb_clock_gen tb_clock_gen_inst (
        .clk_o (clk)
    );

    ex_stage_top ex_stage_top_inst (
        .clk         (clk),
        .resetn      (resetn),
        .valid_i     (valid),
        .ready_i     (ready),
        .pc_i        (pc),
        .inst_i      (inst),
        .rdata1_i    (rdata1),
        .rdata2_i    (rdata2),
        .done_o      (done),
        .valid_o     (valid_out),
        .branch_o    (branch),
        .exc_o       (exc),
        .target_pc_o (target_pc),
        .result_o    (result),
        .waddr_o     (waddr),
        .exc_code_o  (exc_code)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("mismatch %s: actual 0x%08h expected 0x%08h (entry %0d)",
                     name, actual, expected, cur_idx);
            $display("Done: errors found");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // instruction encoders use rs field 1 and rt field 2 where unused
    function automatic logic [31:0] enc_r(input logic [5:0] op, input logic [5:0] funct,
                                          input logic [4:0] rd, input logic [4:0] sa);
        return {op, 5'd1, 5'd2, rd, sa, funct};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [15:0] imm);
        return {op, 5'd1, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic logic [31:0] branch_target(input logic [31:0] pc_v,
                                                  input logic [15:0] imm);
        return pc_v + 32'd4 + {{14{imm[15]}}, imm, 2'b00};
    endfunction

    function automatic logic [31:0] jump_target(input logic [31:0] pc_v,
                                                input logic [25:0] idx);
        logic [31:0] seq;
        seq = pc_v + 32'd4;
        return {seq[31:28], idx, 2'b00};
    endfunction

    task automatic push_entry(input logic [31:0] i_w, input logic [31:0] pc_v,
                              input logic [31:0] rs, input logic [31:0] rt,
                              input logic [31:0] res, input logic [4:0] wa,
                              input logic chk, input logic br, input logic [31:0] tgt,
                              input logic ex, input logic [4:0] code,
                              input logic [5:0] min_wait);
        entry_t e;
        e = '{i_w, pc_v, rs, rt, res, wa, chk, br, tgt, ex, code, min_wait};
        tests.push_back(e);
    endtask

    task automatic add_alu(input logic [31:0] i_w, input logic [31:0] rs,
                           input logic [31:0] rt, input logic [31:0] res,
                           input logic [4:0] wa);
        push_entry(i_w, ALU_PC, rs, rt, res, wa, 1'b1, 1'b0, '0, 1'b0, 5'h00, '0);
    endtask

    task automatic add_exc(input logic [31:0] i_w, input logic [31:0] rs,
                           input logic [31:0] rt, input logic [4:0] code);
        push_entry(i_w, ALU_PC, rs, rt, '0, '0, 1'b0, 1'b0, '0, 1'b1, code, '0);
    endtask

    task automatic add_branch(input logic [31:0] i_w, input logic [31:0] pc_v,
                              input logic [31:0] rs, input logic [31:0] rt,
                              input logic taken, input logic [31:0] tgt);
        push_entry(i_w, pc_v, rs, rt, '0, '0, 1'b0, taken, tgt, 1'b0, 5'h00, '0);
    endtask

    // link value is pc+8
    task automatic add_link(input logic [31:0] i_w, input logic [31:0] pc_v,
                            input logic [31:0] rs, input logic [31:0] tgt,
                            input logic [4:0] wa);
        push_entry(i_w, pc_v, rs, '0, pc_v + 32'd8, wa, 1'b1, 1'b1, tgt, 1'b0, 5'h00, '0);
    endtask

    // done may not rise before count+1 cycles
    task automatic add_count(input logic [31:0] i_w, input logic [31:0] rs,
                             input logic [5:0] count, input logic [4:0] wa);
        push_entry(i_w, ALU_PC, rs, '0, {26'd0, count}, wa, 1'b1, 1'b0, '0, 1'b0, 5'h00,
                   count + 6'd1);
    endtask

    task automatic build_table();
        add_alu(enc_r(6'h00, 6'h21, 5'd3, 5'd0), 32'h0000_0005, 32'h0000_0007, 32'h0000_000c, 5'd3);
        add_alu(enc_r(6'h00, 6'h20, 5'd4, 5'd0), 32'h1234_5678, 32'h1111_1111, 32'h2345_6789, 5'd4);
        add_alu(enc_r(6'h00, 6'h23, 5'd5, 5'd0), 32'h0000_0010, 32'h0000_0020, 32'hffff_fff0, 5'd5);
        add_alu(enc_r(6'h00, 6'h22, 5'd27, 5'd0), 32'h0000_0005, 32'h0000_0007, 32'hffff_fffe, 5'd27);
        add_alu(enc_r(6'h00, 6'h24, 5'd6, 5'd0), 32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000, 5'd6);
        add_alu(enc_r(6'h00, 6'h25, 5'd7, 5'd0), 32'hf0f0_f0f0, 32'h0f00_0f00, 32'hfff0_fff0, 5'd7);
        add_alu(enc_r(6'h00, 6'h26, 5'd8, 5'd0), 32'hffff_0000, 32'h0f0f_0f0f, 32'hf0f0_0f0f, 5'd8);
        add_alu(enc_r(6'h00, 6'h27, 5'd9, 5'd0), 32'hf0f0_0000, 32'h0000_000f, 32'h0f0f_fff0, 5'd9);
        add_alu(enc_r(6'h00, 6'h2a, 5'd10, 5'd0), 32'hffff_ffff, 32'h0000_0001, 32'h1, 5'd10);
        add_alu(enc_r(6'h00, 6'h2b, 5'd11, 5'd0), 32'hffff_ffff, 32'h0000_0001, 32'h0, 5'd11);
        add_alu(enc_r(6'h00, 6'h00, 5'd12, 5'd4), 32'h0, 32'h8000_0001, 32'h0000_0010, 5'd12);
        add_alu(enc_r(6'h00, 6'h02, 5'd13, 5'd8), 32'h0, 32'h8000_0000, 32'h0080_0000, 5'd13);
        add_alu(enc_r(6'h00, 6'h03, 5'd14, 5'd8), 32'h0, 32'h8000_0000, 32'hff80_0000, 5'd14);
        add_alu(enc_r(6'h00, 6'h04, 5'd15, 5'd0), 32'h0000_0024, 32'h0000_0001, 32'h10, 5'd15);
        add_alu(enc_r(6'h00, 6'h07, 5'd16, 5'd0), 32'h0000_0004, 32'hf000_0000, 32'hff00_0000, 5'd16);
        add_alu(enc_r(6'h00, 6'h06, 5'd17, 5'd0), 32'h0000_001f, 32'h8000_0000, 32'h1, 5'd17);
        // immediate forms
        add_alu(enc_i(6'h08, 5'd18, 16'hffff), 32'h0000_0010, 32'h0, 32'h0000_000f, 5'd18);
        add_alu(enc_i(6'h09, 5'd19, 16'h8000), 32'h0, 32'h0, 32'hffff_8000, 5'd19);
        add_alu(enc_i(6'h0a, 5'd20, 16'hfffe), 32'hffff_fffd, 32'h0, 32'h1, 5'd20);
        add_alu(enc_i(6'h0b, 5'd21, 16'hffff), 32'h0000_0005, 32'h0, 32'h1, 5'd21);
        add_alu(enc_i(6'h0c, 5'd22, 16'hffff), 32'hffff_1234, 32'h0, 32'h0000_1234, 5'd22);
        add_alu(enc_i(6'h0d, 5'd23, 16'h8000), 32'h0000_0001, 32'h0, 32'h0000_8001, 5'd23);
        add_alu(enc_i(6'h0e, 5'd24, 16'hffff), 32'hffff_00ff, 32'h0, 32'hffff_ff00, 5'd24);
        add_alu(enc_i(6'h0f, 5'd25, 16'habcd), 32'h0, 32'h0, 32'habcd_0000, 5'd25);
        // overflow and reserved
        add_exc(enc_r(6'h00, 6'h20, 5'd4, 5'd0), 32'h7fff_ffff, 32'h0000_0001, CODE_OV);
        add_alu(enc_r(6'h00, 6'h21, 5'd26, 5'd0), 32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000, 5'd26);
        add_exc(enc_r(6'h00, 6'h22, 5'd4, 5'd0), 32'h8000_0000, 32'h0000_0001, CODE_OV);
        add_exc(enc_i(6'h08, 5'd4, 16'h0010), 32'h7fff_fff0, 32'h0, CODE_OV);
        add_exc(enc_i(6'h3f, 5'd4, 16'h1234), 32'h0, 32'h0, CODE_RI);
        add_exc(enc_r(6'h00, 6'h01, 5'd4, 5'd0), 32'h0, 32'h0, CODE_RI);
        // branches and jumps
        add_branch(enc_i(6'h04, 5'd2, 16'h0010), BR_PC, 32'h55, 32'h55, 1'b1,
                   branch_target(BR_PC, 16'h0010));
        add_branch(enc_i(6'h04, 5'd2, 16'h0010), BR_PC, 32'h1, 32'h2, 1'b0, '0);
        add_branch(enc_i(6'h05, 5'd2, 16'hfff0), BR_PC, 32'h1, 32'h2, 1'b1,
                   branch_target(BR_PC, 16'hfff0));
        add_branch(enc_i(6'h06, 5'd0, 16'h0008), BR_PC, 32'h0, 32'h0, 1'b1,
                   branch_target(BR_PC, 16'h0008));
        add_branch(enc_i(6'h07, 5'd0, 16'h0001), BR_PC, 32'h8000_0000, 32'h0, 1'b0, '0);
        add_branch(enc_i(6'h07, 5'd0, 16'h0001), BR_PC, 32'h5, 32'h0, 1'b1,
                   branch_target(BR_PC, 16'h0001));
        add_branch(enc_i(6'h01, 5'd0, 16'h0002), BR_PC, 32'hffff_ffff, 32'h0, 1'b1,
                   branch_target(BR_PC, 16'h0002));
        add_branch(enc_i(6'h01, 5'd1, 16'h0002), BR_PC, 32'h8000_0000, 32'h0, 1'b0, '0);
        add_branch(enc_i(6'h01, 5'd1, 16'h0003), BR_PC, 32'h0, 32'h0, 1'b1,
                   branch_target(BR_PC, 16'h0003));
        add_branch(enc_j(6'h02, 26'h012_3456), J_PC, 32'h0, 32'h0, 1'b1,
                   jump_target(J_PC, 26'h012_3456));
        add_branch(enc_r(6'h00, 6'h08, 5'd0, 5'd0), BR_PC, 32'h0040_2000, 32'h0, 1'b1,
                   32'h0040_2000);
        add_link(enc_j(6'h03, 26'h000_0040), J_PC, 32'h0, jump_target(J_PC, 26'h000_0040), 5'd31);
        add_link(enc_r(6'h00, 6'h09, 5'd30, 5'd0), BR_PC, 32'h0040_3000, 32'h0040_3000, 5'd30);
        // leading count with clz then clo
        add_count(enc_r(6'h1c, 6'h20, 5'd2, 5'd0), 32'h8000_0000, 6'd0, 5'd2);
        add_count(enc_r(6'h1c, 6'h20, 5'd3, 5'd0), 32'h0001_0000, 6'd15, 5'd3);
        add_count(enc_r(6'h1c, 6'h20, 5'd4, 5'd0), 32'h0000_0000, 6'd32, 5'd4);
        add_count(enc_r(6'h1c, 6'h21, 5'd5, 5'd0), 32'hfff0_0000, 6'd12, 5'd5);
        add_count(enc_r(6'h1c, 6'h21, 5'd6, 5'd0), 32'hffff_ffff, 6'd32, 5'd6);
        add_count(enc_r(6'h1c, 6'h21, 5'd7, 5'd0), 32'h7fff_ffff, 6'd0, 5'd7);
    endtask

    // called on the falling edge once the registers have settled
    task automatic verify_output_reg();
        check_value("valid_o", valid_out, exp_valid);
        if (exp_valid) begin
            check_value("waddr_o", waddr, exp_waddr);
        end
        if (exp_chk) begin
            check_value("result_o", result, exp_result);
        end
        if (!last_ready) begin
            check_value("result_o", result, prev_result);
            check_value("waddr_o", waddr, prev_waddr);
        end
        prev_result = result;
        prev_waddr  = waddr;
    endtask

    task automatic run_entry(input entry_t e);
        int   cycles;
        int   branch_cnt;
        int   exc_cnt;
        logic accepted;
        logic seen_done;
        cycles     = 0;
        branch_cnt = 0;
        exc_cnt    = 0;
        accepted   = 1'b0;
        seen_done  = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            verify_output_reg();
            valid     = 1'b1;
            pc        = e.pc;
            inst      = e.inst;
            rdata1    = e.rs;
            rdata2    = e.rt;
            rand_word = $urandom;
            ready     = (rand_word % 4) != 0;
            @(posedge clk);
            if (cycles < e.min_wait) begin
                check_value("done_o", done, 1'b0);
            end else if (e.min_wait == 0 || seen_done) begin
                check_value("done_o", done, 1'b1);
            end
            if (done) begin
                seen_done = 1'b1;
            end
            if (branch) begin
                branch_cnt++;
                check_value("target_pc_o", target_pc, e.target);
            end
            if (exc) begin
                exc_cnt++;
                check_value("exc_code_o", exc_code, e.code);
            end
            if (ready && done) begin
                accepted   = 1'b1;
                check_value("exc_code_o", exc_code, e.code);
                exp_valid  = !e.exc;
                exp_chk    = e.chk_res && !e.exc;
                exp_result = e.result;
                exp_waddr  = e.waddr;
            end else if (ready) begin
                exp_valid = 1'b0;
                exp_chk   = 1'b0;
            end
            last_ready = ready;
            cycles++;
        end
        check_value("branch_o pulses", branch_cnt, e.branch);
        check_value("exc_o pulses", exc_cnt, e.exc);
    endtask

    initial begin
        resetn      = 1'b0;
        valid       = 1'b0;
        ready       = 1'b0;
        pc          = '0;
        inst        = '0;
        rdata1      = '0;
        rdata2      = '0;
        error_count = 0;
        cur_idx     = 0;
        exp_valid   = 1'b0;
        exp_chk     = 1'b0;
        exp_result  = '0;
        exp_waddr   = '0;
        prev_result = '0;
        prev_waddr  = '0;
        last_ready  = 1'b1;
        rand_word   = $urandom(16);
        build_table();
        limit_cycles = tests.size() * (MAX_COUNT_CYCLES + STALL_MARGIN) + RESET_CYCLES + 4;
        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b1;
        foreach (tests[i]) begin
            cur_idx = i;
            run_entry(tests[i]);
        end
        @(negedge clk);
        verify_output_reg();
        valid = 1'b0;
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("error: the run timed out after %0d cycles in entry %0d",
                 limit_cycles, cur_idx);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o
);

    // 20 ns period
    localparam int HALF_PERIOD = 10;

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// ==== source/ex_stage_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_stage_top import ex_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  resetn,
    input  wire logic                  valid_i,
    input  wire logic                  ready_i,
    input  wire logic [XLEN-1:0]       pc_i,
    input  wire logic [XLEN-1:0]       inst_i,
    input  wire logic [XLEN-1:0]       rdata1_i,
    input  wire logic [XLEN-1:0]       rdata2_i,
    output logic                       done_o,
    output logic                       valid_o,
    output logic                       branch_o,
    output logic                       exc_o,
    output logic [XLEN-1:0]            target_pc_o,
    output logic [XLEN-1:0]            result_o,
    output logic [REG_ADDR_W-1:0]      waddr_o,
    output exc_code_t                  exc_code_o
);

    ex_op_t                op;
    alu_op_t               alu_op;
    logic [XLEN-1:0]       alu_a;
    logic [XLEN-1:0]       alu_b;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       alu_result;
    logic                  overflow;
    logic                  branch_taken;
    logic [BITCOUNT_W-1:0] count;
    logic                  count_ready;
    logic                  release_cnt;

    ex_decode ex_decode_inst (
        .inst_i     (inst_i),
        .rdata1_i   (rdata1_i),
        .rdata2_i   (rdata2_i),
        .op_o       (op),
        .alu_op_o   (alu_op),
        .alu_a_o    (alu_a),
        .alu_b_o    (alu_b),
        .waddr_o    (waddr)
    );

    ex_execute ex_execute_inst (
        .clk            (clk),
        .resetn         (resetn),
        .valid_i        (valid_i),
        .op_i           (op),
        .alu_op_i       (alu_op),
        .alu_a_i        (alu_a),
        .alu_b_i        (alu_b),
        .rdata1_i       (rdata1_i),
        .rdata2_i       (rdata2_i),
        .inst_i         (inst_i),
        .pc_i           (pc_i),
        .release_i      (release_cnt),
        .alu_result_o   (alu_result),
        .overflow_o     (overflow),
        .branch_taken_o (branch_taken),
        .target_pc_o    (target_pc_o),
        .count_o        (count),
        .count_ready_o  (count_ready)
    );

    ex_result ex_result_inst (
        .clk            (clk),
        .resetn         (resetn),
        .valid_i        (valid_i),
        .ready_i        (ready_i),
        .op_i           (op),
        .pc_i           (pc_i),
        .alu_result_i   (alu_result),
        .overflow_i     (overflow),
        .branch_taken_i (branch_taken),
        .count_i        (count),
        .count_ready_i  (count_ready),
        .waddr_i        (waddr),
        .done_o         (done_o),
        .release_o      (release_cnt),
        .branch_o       (branch_o),
        .exc_o          (exc_o),
        .exc_code_o     (exc_code_o),
        .valid_o        (valid_o),
        .result_o       (result_o),
        .waddr_o        (waddr_o)
    );

endmodule

`default_nettype wire

// ==== source/ex_result.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_result import ex_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  resetn,
    input  wire logic                  valid_i,
    input  wire logic                  ready_i,
    input  wire ex_op_t                op_i,
    input  wire logic [XLEN-1:0]       pc_i,
    input  wire logic [XLEN-1:0]       alu_result_i,
    input  wire logic                  overflow_i,
    input  wire logic                  branch_taken_i,
    input  wire logic [BITCOUNT_W-1:0] count_i,
    input  wire logic                  count_ready_i,
    input  wire logic [REG_ADDR_W-1:0] waddr_i,
    output logic                       done_o,
    output logic                       release_o,
    output logic                       branch_o,
    output logic                       exc_o,
    output exc_code_t                  exc_code_o,
    output logic                       valid_o,
    output logic [XLEN-1:0]            result_o,
    output logic [REG_ADDR_W-1:0]      waddr_o
);

    logic            is_count;
    logic            is_link;
    logic            reserved;
    logic            exc;
    logic            fired;
    logic            first;
    logic [XLEN-1:0] result;

    assign is_count = (op_i == OP_CLZ) || (op_i == OP_CLO);
    assign is_link  = (op_i == OP_JAL) || (op_i == OP_JALR);
    assign reserved = (op_i == OP_RESERVED);
    assign exc      = reserved || overflow_i;

    always_comb begin
        if (reserved) begin
            exc_code_o = EXC_RI;
        end else if (overflow_i) begin
            exc_code_o = EXC_OV;
        end else begin
            exc_code_o = EXC_NONE;
        end
    end

    // multi-cycle only for the bit count
    assign done_o    = valid_i && (!is_count || count_ready_i);
    assign release_o = done_o && ready_i;

    // remembers a strobe already given while stalled
    always_ff @(posedge clk) begin
        if (!resetn) begin
            fired <= 1'b0;
        end else if (ready_i) begin
            fired <= 1'b0;
        end else if (done_o) begin
            fired <= 1'b1;
        end
    end

    assign first    = done_o && !fired;
    assign branch_o = first && branch_taken_i;
    assign exc_o    = first && exc;

    always_comb begin
        if (is_link) begin
            result = pc_i + 32'd8;
        end else if (is_count) begin
            result = {{(XLEN-BITCOUNT_W){1'b0}}, count_i};
        end else begin
            result = alu_result_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_o  <= 1'b0;
            result_o <= '0;
            waddr_o  <= '0;
        end else if (ready_i) begin
            valid_o  <= valid_i && done_o && !exc;
            result_o <= result;
            waddr_o  <= waddr_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/ex_execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_execute import ex_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  resetn,
    input  wire logic                  valid_i,
    input  wire ex_op_t                op_i,
    input  wire alu_op_t               alu_op_i,
    input  wire logic [XLEN-1:0]       alu_a_i,
    input  wire logic [XLEN-1:0]       alu_b_i,
    input  wire logic [XLEN-1:0]       rdata1_i,
    input  wire logic [XLEN-1:0]       rdata2_i,
    input  wire logic [XLEN-1:0]       inst_i,
    input  wire logic [XLEN-1:0]       pc_i,
    input  wire logic                  release_i,
    output logic [XLEN-1:0]            alu_result_o,
    output logic                       overflow_o,
    output logic                       branch_taken_o,
    output logic [XLEN-1:0]            target_pc_o,
    output logic [BITCOUNT_W-1:0]      count_o,
    output logic                       count_ready_o
);

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [4:0]      shamt;
    logic            add_ov;
    logic            sub_ov;
    logic            rs_zero;
    logic            rs_neg;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] j_target;
    logic            count_start;
    logic [XLEN-1:0] count_data;

    assign sum   = alu_a_i + alu_b_i;
    assign diff  = alu_a_i - alu_b_i;
    assign shamt = alu_a_i[4:0];

    // signed overflow from the operand and result signs
    assign add_ov = (alu_a_i[XLEN-1] == alu_b_i[XLEN-1]) && (sum[XLEN-1] != alu_a_i[XLEN-1]);
    assign sub_ov = (alu_a_i[XLEN-1] != alu_b_i[XLEN-1]) && (diff[XLEN-1] != alu_a_i[XLEN-1]);

    assign overflow_o = ((op_i == OP_ADD || op_i == OP_ADDI) && add_ov)
                     || (op_i == OP_SUB && sub_ov);

    always_comb begin
        case (alu_op_i)
            ALU_SUB:  alu_result_o = diff;
            ALU_AND:  alu_result_o = alu_a_i & alu_b_i;
            ALU_OR:   alu_result_o = alu_a_i | alu_b_i;
            ALU_XOR:  alu_result_o = alu_a_i ^ alu_b_i;
            ALU_NOR:  alu_result_o = ~(alu_a_i | alu_b_i);
            ALU_SLT:  alu_result_o = {{(XLEN-1){1'b0}}, $signed(alu_a_i) < $signed(alu_b_i)};
            ALU_SLTU: alu_result_o = {{(XLEN-1){1'b0}}, alu_a_i < alu_b_i};
            ALU_SLL:  alu_result_o = alu_b_i << shamt;
            ALU_SRL:  alu_result_o = alu_b_i >> shamt;
            ALU_SRA:  alu_result_o = $signed(alu_b_i) >>> shamt;
            ALU_LUI:  alu_result_o = {alu_b_i[15:0], 16'h0000};
            default:  alu_result_o = sum;
        endcase
    end

    // branch compare
    assign rs_zero = (rdata1_i == '0);
    assign rs_neg  = rdata1_i[XLEN-1];

    always_comb begin
        case (op_i)
            OP_BEQ:                          branch_taken_o = (rdata1_i == rdata2_i);
            OP_BNE:                          branch_taken_o = (rdata1_i != rdata2_i);
            OP_BLEZ:                         branch_taken_o = rs_neg || rs_zero;
            OP_BGTZ:                         branch_taken_o = !rs_neg && !rs_zero;
            OP_BLTZ:                         branch_taken_o = rs_neg;
            OP_BGEZ:                         branch_taken_o = !rs_neg;
            OP_J, OP_JAL, OP_JR, OP_JALR:    branch_taken_o = 1'b1;
            default:                         branch_taken_o = 1'b0;
        endcase
    end

    assign pc_next   = pc_i + 32'd4;
    assign br_target = pc_next + {{(XLEN-18){inst_i[15]}}, inst_i[15:0], 2'b00};
    assign j_target  = {pc_next[31:28], inst_i[25:0], 2'b00};

    always_comb begin
        case (op_i)
            OP_JR, OP_JALR: target_pc_o = rdata1_i;
            OP_J, OP_JAL:   target_pc_o = j_target;
            default:        target_pc_o = br_target;
        endcase
    end

    // clz counts the leading ones of the inverted operand
    assign count_start = valid_i && (op_i == OP_CLZ || op_i == OP_CLO);
    assign count_data  = (op_i == OP_CLZ) ? ~rdata1_i : rdata1_i;

    ex_bitcount ex_bitcount_inst (
        .clk        (clk),
        .resetn     (resetn),
        .start_i    (count_start),
        .release_i  (release_i),
        .data_i     (count_data),
        .count_o    (count_o),
        .ready_o    (count_ready_o)
    );

endmodule

`default_nettype wire

// ==== source/ex_bitcount.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_bitcount import ex_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  resetn,
    input  wire logic                  start_i,
    input  wire logic                  release_i,
    input  wire logic [XLEN-1:0]       data_i,
    output logic [BITCOUNT_W-1:0]      count_o,
    output logic                       ready_o
);

    logic            busy;
    logic [XLEN-1:0] shift_q;
    logic            load;
    logic            step;

    assign load = !busy && start_i;
    // advance while the top bit is still a one
    assign step = busy && shift_q[XLEN-1];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy    <= 1'b0;
            count_o <= '0;
        end else if (release_i) begin
            busy    <= 1'b0;
        end else if (load) begin
            busy    <= 1'b1;
            count_o <= '0;
        end else if (step) begin
            count_o <= count_o + 1'b1;
        end
    end

    // zeros shift in, so all ones ends after the last bit
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= data_i;
        end else if (step) begin
            shift_q <= shift_q << 1;
        end
    end

    assign ready_o = busy && !shift_q[XLEN-1];

endmodule

`default_nettype wire

// ==== source/ex_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_decode import ex_pkg::*; (
    input  wire logic [XLEN-1:0]       inst_i,
    input  wire logic [XLEN-1:0]       rdata1_i,
    input  wire logic [XLEN-1:0]       rdata2_i,
    output ex_op_t                     op_o,
    output alu_op_t                    alu_op_o,
    output logic [XLEN-1:0]            alu_a_o,
    output logic [XLEN-1:0]            alu_b_o,
    output logic [REG_ADDR_W-1:0]      waddr_o
);

    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [4:0]            sa;
    logic [15:0]           imm;
    ex_op_t                op;
    logic                  a_is_sa;
    logic                  b_is_imm;
    logic                  imm_zx;

    assign opcode = inst_i[31:26];
    assign funct  = inst_i[5:0];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign sa     = inst_i[10:6];
    assign imm    = inst_i[15:0];

    always_comb begin
        op = OP_RESERVED;
        case (opcode)
            6'h00: begin
                case (funct)
                    6'h00: op = OP_SLL;
                    6'h02: op = OP_SRL;
                    6'h03: op = OP_SRA;
                    6'h04: op = OP_SLLV;
                    6'h06: op = OP_SRLV;
                    6'h07: op = OP_SRAV;
                    6'h08: op = OP_JR;
                    6'h09: op = OP_JALR;
                    6'h20: op = OP_ADD;
                    6'h21: op = OP_ADDU;
                    6'h22: op = OP_SUB;
                    6'h23: op = OP_SUBU;
                    6'h24: op = OP_AND;
                    6'h25: op = OP_OR;
                    6'h26: op = OP_XOR;
                    6'h27: op = OP_NOR;
                    6'h2a: op = OP_SLT;
                    6'h2b: op = OP_SLTU;
                    default: op = OP_RESERVED;
                endcase
            end
            // regimm, selected by rt
            6'h01: begin
                if (rt == 5'h00) begin
                    op = OP_BLTZ;
                end else if (rt == 5'h01) begin
                    op = OP_BGEZ;
                end
            end
            6'h02: op = OP_J;
            6'h03: op = OP_JAL;
            6'h04: op = OP_BEQ;
            6'h05: op = OP_BNE;
            6'h06: op = OP_BLEZ;
            6'h07: op = OP_BGTZ;
            6'h08: op = OP_ADDI;
            6'h09: op = OP_ADDIU;
            6'h0a: op = OP_SLTI;
            6'h0b: op = OP_SLTIU;
            6'h0c: op = OP_ANDI;
            6'h0d: op = OP_ORI;
            6'h0e: op = OP_XORI;
            6'h0f: op = OP_LUI;
            6'h1c: begin
                if (funct == 6'h20) begin
                    op = OP_CLZ;
                end else if (funct == 6'h21) begin
                    op = OP_CLO;
                end
            end
            default: op = OP_RESERVED;
        endcase
    end

    assign op_o = op;

    always_comb begin
        case (op)
            OP_SUB, OP_SUBU:            alu_op_o = ALU_SUB;
            OP_AND, OP_ANDI:            alu_op_o = ALU_AND;
            OP_OR, OP_ORI:              alu_op_o = ALU_OR;
            OP_XOR, OP_XORI:            alu_op_o = ALU_XOR;
            OP_NOR:                     alu_op_o = ALU_NOR;
            OP_SLT, OP_SLTI:            alu_op_o = ALU_SLT;
            OP_SLTU, OP_SLTIU:          alu_op_o = ALU_SLTU;
            OP_SLL, OP_SLLV:            alu_op_o = ALU_SLL;
            OP_SRL, OP_SRLV:            alu_op_o = ALU_SRL;
            OP_SRA, OP_SRAV:            alu_op_o = ALU_SRA;
            OP_LUI:                     alu_op_o = ALU_LUI;
            default:                    alu_op_o = ALU_ADD;
        endcase
    end

    assign a_is_sa  = op inside {OP_SLL, OP_SRL, OP_SRA};
    assign b_is_imm = op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                                 OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    // logic immediates are zero-extended
    assign imm_zx   = op inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI};

    assign alu_a_o = a_is_sa ? {{(XLEN-5){1'b0}}, sa} : rdata1_i;

    always_comb begin
        if (!b_is_imm) begin
            alu_b_o = rdata2_i;
        end else if (imm_zx) begin
            alu_b_o = {{(XLEN-16){1'b0}}, imm};
        end else begin
            alu_b_o = {{(XLEN-16){imm[15]}}, imm};
        end
    end

    always_comb begin
        case (op)
            OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
            OP_AND, OP_OR, OP_XOR, OP_NOR,
            OP_SLT, OP_SLTU, OP_JALR,
            OP_CLZ, OP_CLO:                         waddr_o = rd;
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI:       waddr_o = rt;
            OP_JAL:                                 waddr_o = LINK_REG;
            // no register write
            default:                                waddr_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int BITCOUNT_W = 6;

    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;

    // every instruction the stage executes
    typedef enum logic [5:0] {
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_JR, OP_JALR,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU,
        OP_BLTZ, OP_BGEZ,
        OP_J, OP_JAL,
        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
        OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
        OP_CLZ, OP_CLO,
        OP_RESERVED
    } ex_op_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    // cp0 cause codes
    typedef enum logic [4:0] {
        EXC_NONE = 5'h00,
        EXC_RI   = 5'h0a,
        EXC_OV   = 5'h0c
    } exc_code_t;

endpackage

`default_nettype wire
